// ==== filelist.f ====
+incdir+verilog
verilog/pf_data_pkg.sv
verilog/pf_ctrl_pkg.sv
verilog/pf_sdpram.sv
verilog/pf_fifo_ctrl.sv
verilog/pf_reg_fifo.sv
verilog/pf_prefetch_fifo.sv
testbench/pf_prefetch_fifo_chk.sv
testbench/pf_prefetch_fifo_tb.sv

// ==== Bender.yml ====
package:
  name: pf_prefetch_fifo

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/pf_data_pkg.sv
      - verilog/pf_ctrl_pkg.sv
      - verilog/pf_sdpram.sv
      - verilog/pf_fifo_ctrl.sv
      - verilog/pf_reg_fifo.sv
      - verilog/pf_prefetch_fifo.sv
  - target: test
    files:
      - testbench/pf_prefetch_fifo_chk.sv
      - testbench/pf_prefetch_fifo_tb.sv

// ==== testbench/pf_prefetch_fifo_tb.sv ====
// prefetch FIFO testbench
// first word, fill to capacity, drain, then random traffic;
// a queue model checks pop order, the bound checker the rest

`default_nettype none

`include "pf_fifo_consts.svh"

module pf_prefetch_fifo_tb;

  localparam int CLK_PERIOD = 4;
  localparam int RST_CYC    = 4;
  localparam int FIRST_CYC  = 10;                     // one word in and out
  localparam int FILL_CYC   = `PF_RAM_DEPTH + 10;
  localparam int DRAIN_CYC  = `PF_RAM_DEPTH + 20;     // used twice
  localparam int RAND_CYC   = 2000;
  localparam int SEED       = 65;
  localparam int WATCH_CYC  = RST_CYC + FIRST_CYC + FILL_CYC + 2 * DRAIN_CYC + RAND_CYC + 200;

  logic                 rd_clk = 1'b0;
  logic                 rd_rst;
  logic                 wr_en;
  logic                 rd_en;
  logic                 wr_vld;
  logic                 rd_vld;
  logic                 almost_full;
  logic                 almost_empty;
  pf_data_pkg::word_t   wr_data;
  pf_data_pkg::word_t   rd_data;
  pf_data_pkg::level_t  water_level;

  pf_data_pkg::word_t   model_q [$];                  // accepted, not yet popped
  pf_data_pkg::word_t   exp_head = '0;
  int                   model_cnt = 0;
  int                   acc_total = 0;                // accepted writes so far
  int                   acc_mark;

  pf_prefetch_fifo dut_i (.*);

  always #(CLK_PERIOD / 2) rd_clk = ~rd_clk;

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic drive_traffic(input int cycles, input int wr_pct, input int rd_pct);
    repeat (cycles)
    begin
      @(posedge rd_clk);
      wr_en   <= int'($urandom % 100) < wr_pct;
      rd_en   <= int'($urandom % 100) < rd_pct;
      wr_data <= pf_data_pkg::word_t'($urandom);
    end
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  always @(posedge rd_clk)
  begin
    if (!rd_rst)
    begin
      if (rd_vld && rd_en && model_q.size() != 0)
        void'(model_q.pop_front());                   // head leaves
      if (wr_en && wr_vld)
      begin
        model_q.push_back(wr_data);
        acc_total++;
      end
    end
    model_cnt = model_q.size();
    exp_head  = (model_q.size() != 0) ? model_q[0] : '0;
  end

  a_pop_order: assert property (@(posedge rd_clk) disable iff (rd_rst)
    rd_vld && rd_en |-> model_cnt != 0 && rd_data == exp_head)
    else stop_with_failure($sformatf("[FAIL] %0t: popped %h, expected %h (%0d held)",
                           $time, $sampled(rd_data), $sampled(exp_head), $sampled(model_cnt)));

  always @(posedge dut_i.chk_i.fail_seen)
    stop_with_failure($sformatf("[FAIL] %0t: bound checker assertion failed", $time));

  initial
  begin
    #(WATCH_CYC * CLK_PERIOD);
    stop_with_failure("timeout: the run did not finish within its cycle budget");
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial
  begin
    void'($urandom(SEED));
    rd_rst  <= 1'b1;
    wr_en   <= 1'b0;
    rd_en   <= 1'b0;
    wr_data <= '0;
    repeat (RST_CYC) @(posedge rd_clk);
    rd_rst  <= 1'b0;
    drive_traffic(1, 100, 0);                         // single word into empty FIFO
    @(posedge rd_clk);
    wr_en   <= 1'b0;
    while (!rd_vld)
      @(posedge rd_clk);
    rd_en   <= 1'b1;
    @(posedge rd_clk);
    rd_en   <= 1'b0;
    @(negedge rd_clk);
    acc_mark = acc_total;
    drive_traffic(FILL_CYC, 100, 0);                  // stall reads, fill up
    @(posedge rd_clk);
    wr_en   <= 1'b0;
    @(negedge rd_clk);
    assert (acc_total - acc_mark == `PF_RAM_DEPTH + 2)
      else stop_with_failure($sformatf("[FAIL] %0t: %0d words accepted, expected %0d",
                             $time, acc_total - acc_mark, `PF_RAM_DEPTH + 2));
    assert (!wr_vld && almost_full && water_level == `PF_RAM_DEPTH)
      else stop_with_failure($sformatf("[FAIL] %0t: full flags wrong, level %0d",
                             $time, water_level));
    drive_traffic(DRAIN_CYC, 0, 100);
    drive_traffic(RAND_CYC / 2, 70, 40);              // write heavy, hits full
    drive_traffic(RAND_CYC / 2, 35, 75);              // read heavy, hits empty
    drive_traffic(DRAIN_CYC, 0, 100);
    @(posedge rd_clk);
    wr_en   <= 1'b0;
    rd_en   <= 1'b0;
    @(negedge rd_clk);
    assert (model_q.size() == 0 && !rd_vld && water_level == '0)
      else stop_with_failure($sformatf("[FAIL] %0t: FIFO not drained, model holds %0d",
                             $time, model_q.size()));
    if (dut_i.chk_i.fail_seen)
      stop_with_failure("bound checker reported an assertion failure");
    else
    begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/pf_prefetch_fifo_chk.sv ====
// prefetch FIFO checker
// bound into the top level; reset state, RAM fill flags,
// first-word latency and output hold under back-pressure

`default_nettype none

`include "pf_fifo_consts.svh"

module pf_prefetch_fifo_chk (
  input wire                       rd_clk,
  input wire                       rd_rst,
  input wire                       wr_en,
  input wire                       wr_vld,
  input wire pf_data_pkg::word_t   wr_data,
  input wire                       rd_en,
  input wire                       rd_vld,
  input wire pf_data_pkg::word_t   rd_data,
  input wire                       ram_rd_q,      // RAM word on its way to the regs
  input wire                       almost_full,
  input wire                       almost_empty,
  input wire pf_data_pkg::level_t  water_level
);

  logic fail_seen = 1'b0;                         // sticky, watched by the testbench
  logic fifo_void;                                // nothing in RAM, regs or flight

  assign fifo_void = (water_level == '0) && !rd_vld && !ram_rd_q;

  task automatic flag_failure(input string what);
    $error("%s", what);
    fail_seen = 1'b1;
  endtask

  //////////////////////////////
  // reset and latency
  //////////////////////////////

  a_reset_state: assert property (@(posedge rd_clk) rd_rst |->
    !rd_vld && wr_vld && almost_empty && !almost_full && water_level == '0)
    else flag_failure("outputs differ from their reset values");

  // accepted at N, RAM read at N+1, register push at N+2
  a_first_word: assert property (@(posedge rd_clk) disable iff (rd_rst)
    wr_en && wr_vld && fifo_void |=>
      !rd_vld ##1 !rd_vld ##1 (rd_vld && rd_data == $past(wr_data, 3)))
    else flag_failure("first word not shown two cycles after its write");

  a_stall_hold: assert property (@(posedge rd_clk) disable iff (rd_rst)
    rd_vld && !rd_en |=> rd_vld && $stable(rd_data))
    else flag_failure("head word moved while the consumer stalled");

  //////////////////////////////
  // RAM fill flags
  //////////////////////////////

  a_level_max: assert property (@(posedge rd_clk) disable iff (rd_rst)
    water_level <= pf_data_pkg::level_t'(`PF_RAM_DEPTH))
    else flag_failure("water_level above RAM depth");

  a_afull: assert property (@(posedge rd_clk) disable iff (rd_rst)
    almost_full == (water_level >= pf_data_pkg::level_t'(`PF_AFULL_LVL)))
    else flag_failure("almost_full does not match water_level");

  a_aempty: assert property (@(posedge rd_clk) disable iff (rd_rst)
    almost_empty == (water_level <= pf_data_pkg::level_t'(`PF_AEMPTY_LVL)))
    else flag_failure("almost_empty does not match water_level");

  a_wr_room: assert property (@(posedge rd_clk) disable iff (rd_rst)
    wr_vld == (water_level != pf_data_pkg::level_t'(`PF_RAM_DEPTH)))
    else flag_failure("wr_vld does not follow RAM full");

endmodule

bind pf_prefetch_fifo pf_prefetch_fifo_chk chk_i (
  .rd_clk       (rd_clk),
  .rd_rst       (rd_rst),
  .wr_en        (wr_en),
  .wr_vld       (wr_vld),
  .wr_data      (wr_data),
  .rd_en        (rd_en),
  .rd_vld       (rd_vld),
  .rd_data      (rd_data),
  .ram_rd_q     (ram_rd_q),
  .almost_full  (almost_full),
  .almost_empty (almost_empty),
  .water_level  (water_level)
);

`default_nettype wire

// ==== verilog/pf_prefetch_fifo.sv ====
// prefetch (show-ahead) FIFO top
// RAM plus pointer controller, with a credit counter that keeps
// the two-entry output register stage filled ahead of reads;
// oldest word shows on rd_data while rd_vld is high

`default_nettype none

module pf_prefetch_fifo (
  input  wire pf_data_pkg::word_t   wr_data,      // write word
  input  wire                       wr_en,        // write request
  output logic                      wr_vld,       // room for a write
  output wire pf_data_pkg::word_t   rd_data,      // head word
  input  wire                       rd_en,        // consumer takes head
  output wire                       rd_vld,       // head word present
  input  wire                       rd_clk,       // single clock
  input  wire                       rd_rst,       // async reset, active high
  output wire                       almost_full,  // RAM nearly full
  output wire                       almost_empty, // RAM nearly empty
  output wire pf_data_pkg::level_t  water_level   // RAM fill count
);

  pf_data_pkg::addr_t   wr_addr;
  pf_data_pkg::addr_t   rd_addr;
  pf_data_pkg::word_t   ram_rd_data;              // RAM read register
  logic                 ram_full;
  logic                 ram_empty;
  logic                 wr_acc;                   // accepted write
  logic                 ram_rd;                   // prefetch read
  logic                 ram_rd_q;                 // read data valid
  logic                 pop;                      // word leaves output
  logic                 crd_room;                 // room after this pop
  pf_ctrl_pkg::credit_e credit;

  //////////////////////////////
  // write side
  //////////////////////////////

  assign wr_vld = ~ram_full;
  assign wr_acc = wr_en & wr_vld;                 // writes while full drop

  //////////////////////////////
  // prefetch credit
  //////////////////////////////

  assign pop = rd_vld & rd_en;

  always_comb
  begin
    case (credit)
      pf_ctrl_pkg::CRD_TWO: crd_room = pop;       // a pop frees one slot
      default:              crd_room = 1'b1;
    endcase
  end

  assign ram_rd = ~ram_empty & crd_room;          // read clock enable too

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
      credit <= pf_ctrl_pkg::CRD_ZERO;
    else
    begin
      case ({ram_rd, pop})
        2'b10:                                    // read issued
          case (credit)
            pf_ctrl_pkg::CRD_ZERO: credit <= pf_ctrl_pkg::CRD_ONE;
            default:               credit <= pf_ctrl_pkg::CRD_TWO;
          endcase
        2'b01:                                    // word popped
          case (credit)
            pf_ctrl_pkg::CRD_TWO:  credit <= pf_ctrl_pkg::CRD_ONE;
            default:               credit <= pf_ctrl_pkg::CRD_ZERO;
          endcase
        default: credit <= credit;                // both or neither
      endcase
    end
  end

  // RAM data is registered, so the push follows the read by one edge
  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
      ram_rd_q <= 1'b0;
    else
      ram_rd_q <= ram_rd;
  end

  //////////////////////////////
  // blocks
  //////////////////////////////

  pf_sdpram u_sdpram (
    .rd_clk  (rd_clk),
    .wr_en   (wr_acc),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_ce   (ram_rd),
    .rd_addr (rd_addr),
    .rd_data (ram_rd_data)
  );

  pf_fifo_ctrl u_fifo_ctrl (
    .rd_clk       (rd_clk),
    .rd_rst       (rd_rst),
    .w_en         (wr_acc),
    .r_en         (ram_rd),
    .waddr        (wr_addr),
    .raddr        (rd_addr),
    .ram_full     (ram_full),
    .ram_empty    (ram_empty),
    .almost_full  (almost_full),
    .almost_empty (almost_empty),
    .water_level  (water_level)
  );

  pf_reg_fifo u_reg_fifo (
    .rd_clk   (rd_clk),
    .rd_rst   (rd_rst),
    .in_vld   (ram_rd_q),                         // paired with ram_rd_data
    .in_data  (ram_rd_data),
    .out_rdy  (rd_en),
    .out_data (rd_data),
    .out_vld  (rd_vld)
  );

endmodule

`default_nettype wire

// ==== verilog/pf_reg_fifo.sv ====
// two-entry register FIFO
// holds prefetched words at the FIFO output; head entry is
// always on out_data, out_vld while any entry is held

`default_nettype none

module pf_reg_fifo (
  input  wire                      rd_clk,    // single clock
  input  wire                      rd_rst,    // async reset, active high
  input  wire                      in_vld,    // push strobe
  input  wire pf_data_pkg::word_t  in_data,   // pushed word
  input  wire                      out_rdy,   // consumer takes head
  output pf_data_pkg::word_t       out_data,  // head word
  output logic                     out_vld    // head word present
);

  pf_ctrl_pkg::reg_occ_e occ;                 // words held
  pf_data_pkg::word_t    head_q;              // oldest entry
  pf_data_pkg::word_t    tail_q;              // second entry
  logic                  pop;

  assign pop = out_vld & out_rdy;             // handshake at the output

  //////////////////////////////
  // occupancy
  //////////////////////////////

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
      occ <= pf_ctrl_pkg::REG_EMPTY;
    else
    begin
      case (occ)
        pf_ctrl_pkg::REG_EMPTY: if (in_vld) occ <= pf_ctrl_pkg::REG_ONE;
        pf_ctrl_pkg::REG_ONE:
          if (in_vld && !pop)
            occ <= pf_ctrl_pkg::REG_TWO;      // fill second slot
          else if (!in_vld && pop)
            occ <= pf_ctrl_pkg::REG_EMPTY;    // last word leaves
        pf_ctrl_pkg::REG_TWO:   if (pop && !in_vld) occ <= pf_ctrl_pkg::REG_ONE;
        default:                occ <= pf_ctrl_pkg::REG_EMPTY;
      endcase
    end
  end

  //////////////////////////////
  // entry data
  //////////////////////////////

  // push lands in the head when it is free after this edge,
  // else in the tail; a pop with two held shifts tail to head
  always_ff @(posedge rd_clk)
  begin
    if (occ == pf_ctrl_pkg::REG_TWO && pop)
      head_q <= tail_q;                       // shift up, order kept
    else if (in_vld && (occ == pf_ctrl_pkg::REG_EMPTY || pop))
      head_q <= in_data;
    if (in_vld && (occ == pf_ctrl_pkg::REG_TWO || (occ == pf_ctrl_pkg::REG_ONE && !pop)))
      tail_q <= in_data;                      // behind the head
  end

  assign out_data = head_q;
  assign out_vld  = (occ != pf_ctrl_pkg::REG_EMPTY);

endmodule

`default_nettype wire

// ==== verilog/pf_fifo_ctrl.sv ====
// FIFO pointer controller
// write and read pointers with wrap bit, full and empty flags,
// registered RAM fill level and almost-full / almost-empty flags

`default_nettype none

`include "pf_fifo_consts.svh"

module pf_fifo_ctrl (
  input  wire                  rd_clk,        // single clock
  input  wire                  rd_rst,        // async reset, active high
  input  wire                  w_en,          // write advance
  input  wire                  r_en,          // read advance
  output pf_data_pkg::addr_t   waddr,         // RAM write address
  output pf_data_pkg::addr_t   raddr,         // RAM read address
  output logic                 ram_full,      // no free RAM entry
  output logic                 ram_empty,     // no word left in RAM
  output logic                 almost_full,   // level at or above afull
  output logic                 almost_empty,  // level at or below aempty
  output pf_data_pkg::level_t  water_level    // RAM fill count
);

  pf_data_pkg::ptr_t wptr;                    // write pointer, msb wraps
  pf_data_pkg::ptr_t rptr;                    // read pointer, msb wraps

  //////////////////////////////
  // pointers
  //////////////////////////////

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
      wptr <= '0;
    else if (w_en)
      wptr <= wptr + pf_data_pkg::ptr_t'(1);  // top never writes when full
  end

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
      rptr <= '0;
    else if (r_en)
      rptr <= rptr + pf_data_pkg::ptr_t'(1);  // top never reads when empty
  end

  assign waddr = wptr[`PF_DEPTH_W-1:0];       // drop wrap bit
  assign raddr = rptr[`PF_DEPTH_W-1:0];

  // same address, opposite lap means the RAM is full
  assign ram_full  = (waddr == raddr) && (wptr[`PF_DEPTH_W] != rptr[`PF_DEPTH_W]);
  assign ram_empty = (wptr == rptr);          // same lap, same address

  //////////////////////////////
  // fill level and thresholds
  //////////////////////////////

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
      water_level <= '0;
    else
    begin
      case ({w_en, r_en})
        2'b10:   water_level <= water_level + pf_data_pkg::level_t'(1);  // write only
        2'b01:   water_level <= water_level - pf_data_pkg::level_t'(1);  // read only
        default: water_level <= water_level;  // both or neither
      endcase
    end
  end

  // compares follow the registered count
  assign almost_full  = (water_level >= pf_data_pkg::level_t'(`PF_AFULL_LVL));
  assign almost_empty = (water_level <= pf_data_pkg::level_t'(`PF_AEMPTY_LVL));

endmodule

`default_nettype wire

// ==== verilog/pf_sdpram.sv ====
// simple dual-port RAM
// one write port, one registered read port with clock enable,
// both on rd_clk; array and read register carry no reset

`default_nettype none

`include "pf_fifo_consts.svh"

module pf_sdpram (
  input  wire                      rd_clk,    // single clock
  input  wire                      wr_en,     // qualified write strobe
  input  wire pf_data_pkg::addr_t  wr_addr,   // write address
  input  wire pf_data_pkg::word_t  wr_data,   // write word
  input  wire                      rd_ce,     // read clock enable
  input  wire pf_data_pkg::addr_t  rd_addr,   // read address
  output pf_data_pkg::word_t       rd_data    // registered read word
);

  //////////////////////////////
  // storage array
  //////////////////////////////

  pf_data_pkg::word_t mem [`PF_RAM_DEPTH];    // block RAM style array

  always_ff @(posedge rd_clk)
  begin
    if (wr_en)
      mem[wr_addr] <= wr_data;                // write port
  end

  //////////////////////////////
  // read port
  //////////////////////////////

  // data register loads only on a prefetch read and holds
  // its word otherwise, so the register FIFO can sample it
  // in the cycle after the read
  always_ff @(posedge rd_clk)
  begin
    if (rd_ce)
      rd_data <= mem[rd_addr];                // one cycle latency
  end

endmodule

`default_nettype wire

// ==== verilog/pf_ctrl_pkg.sv ====
// prefetch FIFO control encodings
// occupancy of the output register stage and prefetch credit

`default_nettype none

package pf_ctrl_pkg;

  // words held in the two-entry register FIFO
  typedef enum logic [1:0] {REG_EMPTY, REG_ONE, REG_TWO} reg_occ_e;

  // held words plus RAM reads still in flight
  typedef enum logic [1:0] {CRD_ZERO, CRD_ONE, CRD_TWO} credit_e;

endpackage

`default_nettype wire

// ==== verilog/pf_data_pkg.sv ====
// prefetch FIFO storage types
// data word, RAM address, wrap pointer and fill level

`default_nettype none

`include "pf_fifo_consts.svh"

package pf_data_pkg;

  typedef logic [`PF_DATA_W-1:0]  word_t;   // one data word
  typedef logic [`PF_DEPTH_W-1:0] addr_t;   // RAM address
  typedef logic [`PF_DEPTH_W:0]   ptr_t;    // address plus wrap bit
  typedef logic [`PF_DEPTH_W:0]   level_t;  // 0 .. PF_RAM_DEPTH

endpackage

`default_nettype wire

// ==== verilog/pf_fifo_consts.svh ====
// prefetch FIFO constants
// widths, RAM depth and fill thresholds shared by every block
// of the show-ahead FIFO

`ifndef PF_FIFO_CONSTS_SVH
`define PF_FIFO_CONSTS_SVH

// RAM geometry
`define PF_DEPTH_W    4                     // address bits, 16 entries
`define PF_DATA_W     16                    // word width
`define PF_RAM_DEPTH  (1 << `PF_DEPTH_W)    // entries in the RAM

// fill thresholds, RAM contents only
`define PF_AFULL_LVL  14                    // almost_full at or above
`define PF_AEMPTY_LVL 1                     // almost_empty at or below

// output stage holds two more words than the RAM
// so total capacity is PF_RAM_DEPTH + 2

`endif
